// ==== hdl/gfx_params.svh ====
`ifndef GFX_PARAMS_SVH
`define GFX_PARAMS_SVH

// horizontal timing, in clocks (one clock is one pixel)
`define GFX_H_VISIBLE 16
`define GFX_H_FRONT   2
`define GFX_H_SYNC    3
`define GFX_H_BACK    3
`define GFX_H_TOTAL   (`GFX_H_VISIBLE + `GFX_H_FRONT + `GFX_H_SYNC + `GFX_H_BACK)

// vertical timing, in lines
`define GFX_V_VISIBLE 12
`define GFX_V_FRONT   1
`define GFX_V_SYNC    2
`define GFX_V_BACK    2
`define GFX_V_TOTAL   (`GFX_V_VISIBLE + `GFX_V_FRONT + `GFX_V_SYNC + `GFX_V_BACK)

// framebuffer geometry
`define GFX_X_BITS     5
`define GFX_Y_BITS     4
`define GFX_ADDR_BITS  8
`define GFX_FB_WORDS   (`GFX_H_VISIBLE * `GFX_V_VISIBLE)
`define GFX_PIXEL_BITS 12

`endif

// ==== hdl/gfx_pkg.sv ====
`default_nettype none

`include "gfx_params.svh"

package gfx_pkg;

  // one colour channel, a third of a pixel
  typedef logic [`GFX_PIXEL_BITS/3-1:0] color_t;

  typedef struct packed {
    color_t red;
    color_t grn;
    color_t blu;
  } rgb_t;

  // the writer stores raw bits, the display side reads the channels
  typedef union packed {
    logic [`GFX_PIXEL_BITS-1:0] raw;
    rgb_t                       rgb;
  } fb_word_u;

endpackage

`default_nettype wire

// ==== hdl/mem_pkg.sv ====
`default_nettype none

`include "gfx_params.svh"

package mem_pkg;

  // linear address, y * line width + x
  typedef logic [`GFX_ADDR_BITS-1:0] fb_addr_t;

  // one framebuffer write request
  typedef struct packed {
    fb_addr_t          addr;
    gfx_pkg::fb_word_u data;
  } fb_wr_t;

endpackage

`default_nettype wire

// ==== hdl/fb_mem_if.sv ====
`default_nettype none

`include "gfx_params.svh"

interface fb_mem_if;
  import gfx_pkg::*;
  import mem_pkg::*;

  // write channel, valid/ready
  logic     wr_valid;
  fb_wr_t   wr_req;
  logic     wr_ready;

  // read channel, fixed one clock latency
  logic     rd_en;
  fb_addr_t rd_addr;
  fb_word_u rd_data;

  modport writer(
    output wr_valid,
    output wr_req,
    input  wr_ready
  );

  modport reader(
    output rd_en,
    output rd_addr,
    input  rd_data
  );

  modport mem(
    input  wr_valid,
    input  wr_req,
    output wr_ready,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

`default_nettype wire

// ==== hdl/fb_mem.sv ====
`default_nettype none

`include "gfx_params.svh"

module fb_mem (
  input wire    clk,
  input wire    reset,
  fb_mem_if.mem mem
);
  import gfx_pkg::*;
  import mem_pkg::*;

  localparam int WORDS = `GFX_FB_WORDS;

  fb_word_u fb_q [0:WORDS-1];

  logic     wr_fire;
  fb_wr_t   wr_req;
  fb_addr_t rd_addr;

  assign wr_req  = mem.wr_req;
  assign rd_addr = mem.rd_addr;

  // display reads own the port, writes only go in idle cycles
  assign mem.wr_ready = ~mem.rd_en;

  // no writes land while the design is held in reset
  assign wr_fire = mem.wr_valid & mem.wr_ready & ~reset;

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      fb_q[wr_req.addr] <= wr_req.data;
    end
  end

  // read data shows up one clock later and holds otherwise
  always_ff @(posedge clk) begin
    if (mem.rd_en) begin
      mem.rd_data <= fb_q[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fb_writer.sv ====
`default_nettype none

`include "gfx_params.svh"

module fb_writer (
  input  wire                     clk,
  input  wire                     reset,
  input  wire [`GFX_X_BITS-1:0]   gfx_x,
  input  wire [`GFX_Y_BITS-1:0]   gfx_y,
  input  gfx_pkg::rgb_t           gfx_color,
  input  wire                     gfx_valid,
  output logic                    gfx_ready,
  fb_mem_if.writer                mem
);
  import mem_pkg::*;

  localparam int AW = `GFX_ADDR_BITS;
  localparam logic [`GFX_X_BITS-1:0] X_LIMIT = `GFX_X_BITS'(`GFX_H_VISIBLE);
  localparam logic [`GFX_Y_BITS-1:0] Y_LIMIT = `GFX_Y_BITS'(`GFX_V_VISIBLE);
  localparam fb_addr_t LINE_WORDS = AW'(`GFX_H_VISIBLE);

  logic     pend_valid;
  fb_wr_t   pend_req;
  logic     accept;
  logic     in_range;
  logic     wr_done;
  fb_addr_t lin_addr;

  assign in_range = (gfx_x < X_LIMIT) && (gfx_y < Y_LIMIT);
  assign lin_addr = AW'(gfx_y) * LINE_WORDS + AW'(gfx_x);

  assign mem.wr_valid = pend_valid;
  assign mem.wr_req   = pend_req;

  assign wr_done   = pend_valid & mem.wr_ready;
  // free slot, or the pending write leaves this cycle
  assign gfx_ready = ~pend_valid | wr_done;
  assign accept    = gfx_valid & gfx_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      pend_valid <= 1'b0;
    end else if (accept) begin
      // off-screen writes are taken but dropped here
      pend_valid <= in_range;
    end else if (wr_done) begin
      pend_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pend_req.addr     <= lin_addr;
      pend_req.data.raw <= gfx_color;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/vga_timing.sv ====
`default_nettype none

`include "gfx_params.svh"

module vga_timing (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     enable,
  output logic [`GFX_X_BITS-1:0]  x,
  output logic [`GFX_Y_BITS-1:0]  y,
  output logic                    visible,
  output logic                    hsync,
  output logic                    vsync
);
  localparam int HB = `GFX_X_BITS;
  localparam int VB = $clog2(`GFX_V_TOTAL);

  localparam logic [HB-1:0] H_LAST   = HB'(`GFX_H_TOTAL - 1);
  localparam logic [HB-1:0] H_VIS    = HB'(`GFX_H_VISIBLE);
  localparam logic [HB-1:0] H_SYNC_S = HB'(`GFX_H_VISIBLE + `GFX_H_FRONT);
  localparam logic [HB-1:0] H_SYNC_E = HB'(`GFX_H_VISIBLE + `GFX_H_FRONT + `GFX_H_SYNC);

  localparam logic [VB-1:0] V_LAST   = VB'(`GFX_V_TOTAL - 1);
  localparam logic [VB-1:0] V_VIS    = VB'(`GFX_V_VISIBLE);
  localparam logic [VB-1:0] V_SYNC_S = VB'(`GFX_V_VISIBLE + `GFX_V_FRONT);
  localparam logic [VB-1:0] V_SYNC_E = VB'(`GFX_V_VISIBLE + `GFX_V_FRONT + `GFX_V_SYNC);

  logic [HB-1:0] h_cnt;
  logic [VB-1:0] v_cnt;

  always_ff @(posedge clk) begin
    if (reset || !enable) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == H_LAST) begin
      h_cnt <= '0;
      // end of line, step the frame
      v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign x = h_cnt;
  // only meaningful inside the visible lines
  assign y = v_cnt[`GFX_Y_BITS-1:0];

  // disabled display never claims the read port
  assign visible = enable && (h_cnt < H_VIS) && (v_cnt < V_VIS);

  // sync pulses are active low
  assign hsync = ~((h_cnt >= H_SYNC_S) && (h_cnt < H_SYNC_E));
  assign vsync = ~((v_cnt >= V_SYNC_S) && (v_cnt < V_SYNC_E));

endmodule

`default_nettype wire

// ==== hdl/vga_fb_pixel_stream.sv ====
`default_nettype none

`include "gfx_params.svh"

module vga_fb_pixel_stream (
  input  wire                     clk,
  input  wire                     reset,
  input  wire [`GFX_X_BITS-1:0]   x,
  input  wire [`GFX_Y_BITS-1:0]   y,
  input  wire                     visible,
  input  wire                     hsync_in,
  input  wire                     vsync_in,
  fb_mem_if.reader                mem,
  output gfx_pkg::color_t         red,
  output gfx_pkg::color_t         grn,
  output gfx_pkg::color_t         blu,
  output logic                    hsync,
  output logic                    vsync
);
  import gfx_pkg::*;

  localparam int AW = `GFX_ADDR_BITS;
  localparam logic [AW-1:0] LINE_WORDS = AW'(`GFX_H_VISIBLE);

  logic vis_d1;
  logic hs_d1;
  logic vs_d1;
  rgb_t pix;

  // read the pixel under the raster right now
  assign mem.rd_en   = visible;
  assign mem.rd_addr = AW'(y) * LINE_WORDS + AW'(x);

  // returned word, decoded as colour channels
  assign pix = mem.rd_data.rgb;

  // first stage, lines up with the read data
  always_ff @(posedge clk) begin
    if (reset) begin
      vis_d1 <= 1'b0;
      hs_d1  <= 1'b1;
      vs_d1  <= 1'b1;
    end else begin
      vis_d1 <= visible;
      hs_d1  <= hsync_in;
      vs_d1  <= vsync_in;
    end
  end

  // second stage, the output registers
  always_ff @(posedge clk) begin
    if (reset) begin
      red   <= '0;
      grn   <= '0;
      blu   <= '0;
      hsync <= 1'b1;
      vsync <= 1'b1;
    end else begin
      hsync <= hs_d1;
      vsync <= vs_d1;
      if (vis_d1) begin
        red <= pix.red;
        grn <= pix.grn;
        blu <= pix.blu;
      end else begin
        // blanking
        red <= '0;
        grn <= '0;
        blu <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/gfx_vga.sv ====
`default_nettype none

`include "gfx_params.svh"

module gfx_vga (
  input  wire                        clk,
  input  wire                        reset,

  // drawing port
  input  wire [`GFX_X_BITS-1:0]      gfx_x,
  input  wire [`GFX_Y_BITS-1:0]      gfx_y,
  input  wire [`GFX_PIXEL_BITS-1:0]  gfx_color,
  input  wire                        gfx_valid,
  output wire                        gfx_ready,

  // vga output
  input  wire                        vga_enable,
  output gfx_pkg::color_t            vga_red,
  output gfx_pkg::color_t            vga_grn,
  output gfx_pkg::color_t            vga_blu,
  output wire                        vga_hsync,
  output wire                        vga_vsync
);
  wire [`GFX_X_BITS-1:0] tim_x;
  wire [`GFX_Y_BITS-1:0] tim_y;
  wire                   tim_visible;
  wire                   tim_hsync;
  wire                   tim_vsync;

  fb_mem_if fb_bus ();

  fb_writer fb_writer_inst (
    .clk      (clk),
    .reset    (reset),
    .gfx_x    (gfx_x),
    .gfx_y    (gfx_y),
    .gfx_color(gfx_color),
    .gfx_valid(gfx_valid),
    .gfx_ready(gfx_ready),
    .mem      (fb_bus.writer)
  );

  fb_mem fb_mem_inst (
    .clk  (clk),
    .reset(reset),
    .mem  (fb_bus.mem)
  );

  vga_timing vga_timing_inst (
    .clk    (clk),
    .reset  (reset),
    .enable (vga_enable),
    .x      (tim_x),
    .y      (tim_y),
    .visible(tim_visible),
    .hsync  (tim_hsync),
    .vsync  (tim_vsync)
  );

  // two clocks behind the timing counters
  vga_fb_pixel_stream vga_fb_pixel_stream_inst (
    .clk     (clk),
    .reset   (reset),
    .x       (tim_x),
    .y       (tim_y),
    .visible (tim_visible),
    .hsync_in(tim_hsync),
    .vsync_in(tim_vsync),
    .mem     (fb_bus.reader),
    .red     (vga_red),
    .grn     (vga_grn),
    .blu     (vga_blu),
    .hsync   (vga_hsync),
    .vsync   (vga_vsync)
  );

endmodule

`default_nettype wire

// ==== verif/gfx_vga_tb.sv ====
`default_nettype none

`include "gfx_params.svh"

module gfx_vga_tb;

  localparam int H_TOTAL       = `GFX_H_TOTAL;
  localparam int V_TOTAL       = `GFX_V_TOTAL;
  localparam int FRAME_CLKS    = H_TOTAL * V_TOTAL;
  localparam int H_SYNC_START  = `GFX_H_VISIBLE + `GFX_H_FRONT;
  localparam int V_SYNC_START  = `GFX_V_VISIBLE + `GFX_V_FRONT;
  localparam int MAX_STALL     = 17;
  localparam int WATCHDOG_CLKS = 6 * FRAME_CLKS + 2000;

  logic                       clk;
  logic                       reset;
  logic [`GFX_X_BITS-1:0]     gfx_x;
  logic [`GFX_Y_BITS-1:0]     gfx_y;
  logic [`GFX_PIXEL_BITS-1:0] gfx_color;
  logic                       gfx_valid;
  logic                       gfx_ready;
  logic                       vga_enable;
  logic [3:0]                 vga_red;
  logic [3:0]                 vga_grn;
  logic [3:0]                 vga_blu;
  logic                       vga_hsync;
  logic                       vga_vsync;
  logic [`GFX_PIXEL_BITS-1:0] pixel_out;

  // reference copy of the framebuffer
  logic [`GFX_PIXEL_BITS-1:0] model [0:`GFX_FB_WORDS-1];

  // raster position of the sampled outputs
  int   cur_h       = 0;
  int   cur_v       = 0;
  logic tracking    = 1'b0;
  logic idle_window = 1'b0;
  logic check_vis   = 1'b0;
  logic offscreen   = 1'b0;
  int   stall_len   = 0;
  logic stall_seen  = 1'b0;

  gfx_vga dut (
    .clk       (clk),
    .reset     (reset),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_color (gfx_color),
    .gfx_valid (gfx_valid),
    .gfx_ready (gfx_ready),
    .vga_enable(vga_enable),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync)
  );

  assign pixel_out = {vga_red, vga_grn, vga_blu};

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic in_view(input int h, input int v);
    in_view = (h < `GFX_H_VISIBLE) && (v < `GFX_V_VISIBLE);
  endfunction

  function automatic logic hsync_expected(input int h);
    hsync_expected = !((h >= H_SYNC_START) && (h < H_SYNC_START + `GFX_H_SYNC));
  endfunction

  function automatic logic vsync_expected(input int v);
    vsync_expected = !((v >= V_SYNC_START) && (v < V_SYNC_START + `GFX_V_SYNC));
  endfunction

  function automatic logic [`GFX_PIXEL_BITS-1:0] expected_pixel(input int h, input int v);
    logic [7:0] idx;
    idx = 8'(v * `GFX_H_VISIBLE + h);
    expected_pixel = in_view(h, v) ? model[idx] : '0;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped by a failed check");
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
    fail_run($sformatf("Fail %s: expected 0x%0h, actual 0x%0h", test, exp, act));
  endtask

  // reset state with the display off
  a_idle_sync: assert property (@(posedge clk) disable iff (reset)
      idle_window |-> (vga_hsync && vga_vsync))
    else report_mismatch("idle_sync", 32'h3, 32'({$sampled(vga_hsync), $sampled(vga_vsync)}));
  a_idle_color: assert property (@(posedge clk) disable iff (reset)
      idle_window |-> (pixel_out == '0))
    else report_mismatch("idle_color", 32'h0, 32'($sampled(pixel_out)));
  a_idle_ready: assert property (@(posedge clk) disable iff (reset)
      idle_window |-> gfx_ready)
    else report_mismatch("idle_ready", 32'h1, 32'($sampled(gfx_ready)));

  // sync pulses against the tracked raster position
  a_hsync: assert property (@(posedge clk) disable iff (reset)
      tracking |-> (vga_hsync == hsync_expected(cur_h)))
    else report_mismatch("hsync", 32'(hsync_expected($sampled(cur_h))),
                         32'($sampled(vga_hsync)));
  a_vsync: assert property (@(posedge clk) disable iff (reset)
      tracking |-> (vga_vsync == vsync_expected(cur_v)))
    else report_mismatch("vsync", 32'(vsync_expected($sampled(cur_v))),
                         32'($sampled(vga_vsync)));

  a_blank: assert property (@(posedge clk) disable iff (reset)
      (tracking && !in_view(cur_h, cur_v)) |-> (pixel_out == '0))
    else report_mismatch("blanking", 32'h0, 32'($sampled(pixel_out)));
  a_pixel: assert property (@(posedge clk) disable iff (reset)
      (check_vis && in_view(cur_h, cur_v)) |-> (pixel_out == expected_pixel(cur_h, cur_v)))
    else report_mismatch("frame_pixel", 32'(expected_pixel($sampled(cur_h), $sampled(cur_v))),
                         32'($sampled(pixel_out)));

  // dropped writes never fill the holding register
  a_drop_ready: assert property (@(posedge clk) disable iff (reset)
      offscreen |-> gfx_ready)
    else report_mismatch("drop_ready", 32'h1, 32'($sampled(gfx_ready)));

  a_stall: assert property (@(posedge clk) disable iff (reset) stall_len <= MAX_STALL)
    else fail_run("gfx_ready stayed low longer than one visible line");

  // first falling vsync at the outputs is line 13, pixel 0
  always @(posedge clk) begin
    if (reset) begin
      tracking <= 1'b0;
      cur_h    <= 0;
      cur_v    <= 0;
    end else if (!tracking) begin
      if (!vga_vsync) begin
        tracking <= 1'b1;
        cur_h    <= 1;
        cur_v    <= V_SYNC_START;
      end
    end else if (cur_h == H_TOTAL - 1) begin
      cur_h <= 0;
      cur_v <= (cur_v == V_TOTAL - 1) ? 0 : cur_v + 1;
    end else begin
      cur_h <= cur_h + 1;
    end
  end

  always @(posedge clk) begin
    if (reset || gfx_ready) begin
      stall_len <= 0;
    end else begin
      stall_len <= stall_len + 1;
    end
    if (!reset && gfx_valid && !gfx_ready) begin
      stall_seen <= 1'b1;
    end
  end

  // holds the request until ready is seen at an edge
  task automatic draw_pixel(input logic [`GFX_X_BITS-1:0] x, input logic [`GFX_Y_BITS-1:0] y,
                            input logic [`GFX_PIXEL_BITS-1:0] c);
    gfx_x     <= x;
    gfx_y     <= y;
    gfx_color <= c;
    gfx_valid <= 1'b1;
    @(posedge clk);
    while (!gfx_ready) @(posedge clk);
    if ((x < `GFX_H_VISIBLE) && (y < `GFX_V_VISIBLE)) begin
      model[8'(y * `GFX_H_VISIBLE + x)] = c;
    end
  endtask

  task automatic wait_writes_done;
    @(posedge clk);
    while (!gfx_ready) @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  // one full frame from pixel (0,0) to the last blanking clock
  task automatic check_frame;
    while (!(cur_h == H_TOTAL - 1 && cur_v == V_TOTAL - 1)) @(posedge clk);
    check_vis <= 1'b1;
    repeat (FRAME_CLKS) @(posedge clk);
    check_vis <= 1'b0;
  endtask

  initial begin
    repeat (WATCHDOG_CLKS) @(posedge clk);
    fail_run($sformatf("Watchdog expired after %0d clocks", WATCHDOG_CLKS));
  end

  initial begin
    void'($urandom(7164));
    reset      = 1'b1;
    gfx_x      = '0;
    gfx_y      = '0;
    gfx_color  = '0;
    gfx_valid  = 1'b0;
    vga_enable = 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    idle_window <= 1'b1;
    repeat (8) @(posedge clk);
    idle_window <= 1'b0;
    vga_enable  <= 1'b1;
    while (!tracking) @(posedge clk);

    // fill every pixel and compare the next frame
    for (int y = 0; y < `GFX_V_VISIBLE; y++) begin
      for (int x = 0; x < `GFX_H_VISIBLE; x++) begin
        draw_pixel(5'(x), 4'(y), 12'($urandom));
      end
    end
    gfx_valid <= 1'b0;
    wait_writes_done();
    check_frame();

    // off-screen writes with x past the line or y past the frame
    offscreen <= 1'b1;
    for (int i = 0; i < 12; i++) begin
      if (i % 2 == 1) begin
        draw_pixel(5'($urandom_range(31, 16)), 4'($urandom_range(15, 0)), 12'($urandom));
      end else begin
        draw_pixel(5'($urandom_range(15, 0)), 4'($urandom_range(15, 12)), 12'($urandom));
      end
    end
    offscreen <= 1'b0;
    gfx_valid <= 1'b0;
    wait_writes_done();
    check_frame();

    // burst that runs into a visible line
    while (!(cur_v == 3 && cur_h == 20)) @(posedge clk);
    for (int i = 0; i < 24; i++) begin
      draw_pixel(5'($urandom_range(15, 0)), 4'($urandom_range(11, 0)), 12'($urandom));
    end
    gfx_valid <= 1'b0;
    wait_writes_done();
    check_frame();

    if (stall_seen) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      fail_run("the write burst never saw gfx_ready held low");
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/gfx_pkg.sv
hdl/mem_pkg.sv
hdl/fb_mem_if.sv
hdl/fb_mem.sv
hdl/fb_writer.sv
hdl/vga_timing.sv
hdl/vga_fb_pixel_stream.sv
hdl/gfx_vga.sv
verif/gfx_vga_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= gfx_vga_tb
RTL_TOP   ?= gfx_vga
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
